//--- Makefile
# Verilator build and run for the AHB-Lite subsystem testbench

TOP = tb_ahb_subsys

.PHONY: all compile run clean

all: run

compile: obj_dir/V$(TOP)

obj_dir/V$(TOP): vlog.f logic/*.sv testbench/*.sv
	verilator --binary --assert --top-module $(TOP) -Mdir obj_dir -f vlog.f

# pass only when the simulation prints the pass line
run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "PASS: all tests"

clean:
	rm -rf obj_dir

//--- logic/ahb_decoder.sv
/*
  AHB-Lite address decoder
  selects the SRAM or the default slave from HADDR and returns
  the data-phase owner's HRDATA, HREADY and HRESP to the master
*/

`timescale 1ns/100ps

module ahb_decoder (
  input  logic                       CLK,
  input  logic                       nRST,
  input  logic [ahb_pkg::ADDR_W-1:0] HADDR,
  input  logic [1:0]                 HTRANS,
  // slave responses
  input  logic                       HREADY_sram,
  input  logic                       HRESP_sram,
  input  logic [ahb_pkg::DATA_W-1:0] HRDATA_sram,
  input  logic                       HREADY_dflt,
  input  logic                       HRESP_dflt,
  // selects and muxed response
  output logic                       HSEL_sram,
  output logic                       HSEL_dflt,
  output logic [ahb_pkg::DATA_W-1:0] HRDATA,
  output logic                       HREADY,
  output logic                       HRESP
);

  logic pend;      // a data phase is in progress
  logic own_sram;  // SRAM owns it, else the default slave

  // region check on the bits above the word index
  assign HSEL_sram = (HADDR >> (ahb_pkg::SRAM_AW + 2)) ==
                     (ahb_pkg::SRAM_BASE >> (ahb_pkg::SRAM_AW + 2));
  assign HSEL_dflt = ~HSEL_sram;

  // ----------------------------------------
  // data phase owner
  // ----------------------------------------
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      pend     <= 1'b0;
      own_sram <= 1'b0;
    end else if (HREADY) begin  // address phase sampled only when ready
      pend     <= (HTRANS == ahb_pkg::HTRANS_NONSEQ);
      own_sram <= HSEL_sram;
    end
  end

  // response mux
  always_comb begin
    if (!pend) begin
      HRDATA = '0;
      HREADY = 1'b1;              // bus free
      HRESP  = ahb_pkg::HRESP_OKAY;
    end else if (own_sram) begin
      HRDATA = HRDATA_sram;
      HREADY = HREADY_sram;
      HRESP  = HRESP_sram;
    end else begin
      HRDATA = '0;                // default slave has no read data
      HREADY = HREADY_dflt;
      HRESP  = HRESP_dflt;
    end
  end

  // the slave without the data phase sits ready with OKAY
  a_owner_only : assert property (@(posedge CLK) disable iff (!nRST)
    pend |-> (own_sram ? (HREADY_dflt && HRESP_dflt == ahb_pkg::HRESP_OKAY)
                       : (HREADY_sram && HRESP_sram == ahb_pkg::HRESP_OKAY)))
    else $error("ahb_decoder: slave without the data phase is not idle");

endmodule

//--- logic/ahb_default_slave.sv
/*
  AHB-Lite default slave
  owns all unmapped space; a selected NONSEQ transfer gets the
  two-cycle ERROR response, IDLE gets OKAY with no wait
*/

`timescale 1ns/100ps

module ahb_default_slave (
  input  logic       CLK,
  input  logic       nRST,
  input  logic       HSEL,
  input  logic [1:0] HTRANS,
  input  logic       HREADY,
  output logic       HREADYOUT,
  output logic       HRESP
);

  logic accept;     // selected NONSEQ sampled this cycle
  logic err_first;  // ERROR with HREADYOUT low
  logic err_last;   // ERROR with HREADYOUT high

  assign accept = HSEL & HREADY & (HTRANS == ahb_pkg::HTRANS_NONSEQ);

  // ----------------------------------------
  // error sequence
  // ----------------------------------------
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      err_first <= 1'b0;
      err_last  <= 1'b0;
    end else begin
      err_first <= accept;     // HREADY is low during err_first
      err_last  <= err_first;
    end
  end

  assign HREADYOUT = ~err_first;
  assign HRESP     = (err_first | err_last) ? ahb_pkg::HRESP_ERROR
                                            : ahb_pkg::HRESP_OKAY;

endmodule

//--- logic/ahb_master.sv
/*
  AHB-Lite master
  turns one generic bus request (ren/wen) into a single NONSEQ
  transfer, waits out the data phase on HREADY and reports an
  ERROR response on the error output
*/

`timescale 1ns/100ps

module ahb_master (
  input  logic                         CLK,
  input  logic                         nRST,
  // generic bus side
  input  logic                         ren,
  input  logic                         wen,
  input  logic [ahb_pkg::ADDR_W-1:0]   addr,
  input  logic [ahb_pkg::DATA_W-1:0]   wdata,
  input  logic [ahb_pkg::DATA_W/8-1:0] byte_en,
  output logic [ahb_pkg::DATA_W-1:0]   rdata,
  output logic                         busy,
  output logic                         error,
  // AHB-Lite side
  output logic [ahb_pkg::ADDR_W-1:0]   HADDR,
  output logic [1:0]                   HTRANS,
  output logic                         HWRITE,
  output logic [2:0]                   HSIZE,
  output logic [ahb_pkg::DATA_W-1:0]   HWDATA,
  input  logic [ahb_pkg::DATA_W-1:0]   HRDATA,
  input  logic                         HREADY,
  input  logic                         HRESP
);

  logic                       req;       // a request is present
  logic                       data_ph;   // state: 0 idle/address, 1 data
  logic                       complete;  // data phase ends this cycle
  logic [2:0]                 size_a;    // size decoded from byte_en
  logic [1:0]                 lane_a;    // lowest enabled byte lane
  logic [ahb_pkg::ADDR_W-1:0] addr_a;    // address with lane bits fixed up
  logic [ahb_pkg::ADDR_W-1:0] haddr_q;   // transfer in flight
  logic                       hwrite_q;
  logic [2:0]                 hsize_q;

  assign req      = ren | wen;
  assign complete = data_ph & HREADY;

  // ----------------------------------------
  // address phase decode
  // ----------------------------------------
  always_comb begin
    case (byte_en)
      4'b1111:          size_a = ahb_pkg::HSIZE_WORD;
      4'b0011, 4'b1100: size_a = ahb_pkg::HSIZE_HALF;
      default:          size_a = ahb_pkg::HSIZE_BYTE;  // single lane
    endcase
  end

  // low address bits point at the first lane written or read
  always_comb begin
    if (byte_en[0])      lane_a = 2'd0;
    else if (byte_en[1]) lane_a = 2'd1;
    else if (byte_en[2]) lane_a = 2'd2;
    else                 lane_a = 2'd3;
  end

  assign addr_a = {addr[ahb_pkg::ADDR_W-1:2], lane_a};

  // ----------------------------------------
  // state and transfer registers
  // ----------------------------------------
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      data_ph <= 1'b0;
    end else if (!data_ph) begin
      data_ph <= req & HREADY;  // address phase accepted
    end else if (HREADY) begin
      data_ph <= 1'b0;          // OKAY done, or second ERROR cycle
    end
  end

  always_ff @(posedge CLK) begin
    if (!data_ph && req && HREADY) begin
      haddr_q  <= addr_a;
      hwrite_q <= wen;
      hsize_q  <= size_a;
    end
  end

  // ----------------------------------------
  // bus outputs
  // ----------------------------------------
  // NONSEQ only in the first cycle, IDLE through wait states
  assign HTRANS = (!data_ph && req) ? ahb_pkg::HTRANS_NONSEQ : ahb_pkg::HTRANS_IDLE;
  assign HADDR  = data_ph ? haddr_q  : addr_a;
  assign HWRITE = data_ph ? hwrite_q : wen;
  assign HSIZE  = data_ph ? hsize_q  : size_a;
  assign HWDATA = data_ph ? wdata : '0;  // requester still holds wdata

  assign rdata = HRDATA;
  assign busy  = data_ph ? ~HREADY : req;
  assign error = complete & (HRESP == ahb_pkg::HRESP_ERROR);

  // requester contract: legal lane pattern, never read and write at once
  a_legal_req : assert property (@(posedge CLK) disable iff (!nRST)
    req |-> !(ren && wen) &&
      (byte_en inside {4'b0001, 4'b0010, 4'b0100, 4'b1000, 4'b0011, 4'b1100, 4'b1111}))
    else $error("ahb_master: illegal request ren=%b wen=%b byte_en=%b", ren, wen, byte_en);

endmodule

//--- logic/ahb_pkg.sv
/*
  AHB-Lite subsystem definitions
  bus widths, transfer codes, memory map and SRAM timing
  shared by the master, the decoder and both slaves
*/

package ahb_pkg;

  // ----------------------------------------
  // bus widths
  // ----------------------------------------
  localparam int ADDR_W = 32;             // HADDR and generic addr
  localparam int DATA_W = 32;             // HWDATA / HRDATA, four byte lanes

  // ----------------------------------------
  // AHB-Lite codes
  // ----------------------------------------
  // HTRANS, only IDLE and NONSEQ are ever issued (no bursts)
  localparam logic [1:0] HTRANS_IDLE   = 2'b00;
  localparam logic [1:0] HTRANS_NONSEQ = 2'b10;

  // HSIZE, log2 of the byte count
  localparam logic [2:0] HSIZE_BYTE = 3'b000;
  localparam logic [2:0] HSIZE_HALF = 3'b001;
  localparam logic [2:0] HSIZE_WORD = 3'b010;

  // HRESP, single bit in AHB-Lite
  localparam logic HRESP_OKAY  = 1'b0;
  localparam logic HRESP_ERROR = 1'b1;

  // ----------------------------------------
  // memory map
  // ----------------------------------------
  // SRAM region must be aligned to its own size
  localparam logic [ADDR_W-1:0] SRAM_BASE = 32'h0000_0000;
  localparam int SRAM_WORDS = 256;                 // depth in 32-bit words
  localparam int SRAM_AW    = $clog2(SRAM_WORDS);  // word index width

  // everything outside [SRAM_BASE, SRAM_BASE + 4*SRAM_WORDS) goes to
  // the default slave and answers ERROR

  // ----------------------------------------
  // SRAM timing
  // ----------------------------------------
  localparam int SRAM_WAIT = 1;           // wait states per transfer

  // wait counter width, kept at least one bit for zero-wait builds
  localparam int WAIT_W = (SRAM_WAIT > 0) ? $clog2(SRAM_WAIT + 1) : 1;

  // value loaded into the wait counter on an accepted transfer
  localparam logic [WAIT_W-1:0] WAIT_LOAD = WAIT_W'(SRAM_WAIT);

endpackage

//--- logic/ahb_sram.sv
/*
  AHB-Lite SRAM slave
  word-organized memory with byte-lane writes, inserts SRAM_WAIT
  wait states on every transfer and always answers OKAY
*/

`timescale 1ns/100ps

module ahb_sram (
  input  logic                       CLK,
  input  logic                       nRST,
  input  logic                       HSEL,
  input  logic [ahb_pkg::ADDR_W-1:0] HADDR,
  input  logic [1:0]                 HTRANS,
  input  logic                       HWRITE,
  input  logic [2:0]                 HSIZE,
  input  logic [ahb_pkg::DATA_W-1:0] HWDATA,
  input  logic                       HREADY,
  output logic [ahb_pkg::DATA_W-1:0] HRDATA,
  output logic                       HREADYOUT,
  output logic                       HRESP
);

  logic [ahb_pkg::DATA_W-1:0]   mem [ahb_pkg::SRAM_WORDS];
  logic                         accept;    // selected NONSEQ sampled
  logic                         active;    // data phase owned here
  logic                         done;      // last data phase cycle
  logic [ahb_pkg::WAIT_W-1:0]   wait_cnt;  // wait states left
  logic [3:0]                   strb_a;    // lanes from address phase
  logic [3:0]                   strb_q;
  logic [ahb_pkg::SRAM_AW-1:0]  idx_q;     // word index
  logic                         write_q;

  assign accept = HSEL & HREADY & (HTRANS == ahb_pkg::HTRANS_NONSEQ);
  assign done   = active & (wait_cnt == '0);

  // lane strobes from size and low address bits
  always_comb begin
    case (HSIZE)
      ahb_pkg::HSIZE_BYTE: strb_a = 4'b0001 << HADDR[1:0];
      ahb_pkg::HSIZE_HALF: strb_a = 4'b0011 << {HADDR[1], 1'b0};
      default:             strb_a = 4'b1111;
    endcase
  end

  // ----------------------------------------
  // data phase control
  // ----------------------------------------
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      active   <= 1'b0;
      wait_cnt <= '0;
    end else if (HREADY) begin
      active   <= accept;  // a new transfer may follow the last cycle
      wait_cnt <= accept ? ahb_pkg::WAIT_LOAD : '0;
    end else if (wait_cnt != '0) begin
      wait_cnt <= wait_cnt - 1'b1;  // HREADY held low by us
    end
  end

  // captured address phase, payload only
  always_ff @(posedge CLK) begin
    if (accept) begin
      idx_q   <= HADDR[ahb_pkg::SRAM_AW+1:2];
      write_q <= HWRITE;
      strb_q  <= strb_a;
    end
  end

  // ----------------------------------------
  // memory array
  // ----------------------------------------
  // HWDATA is valid by the last data cycle, merge per lane
  always_ff @(posedge CLK) begin
    if (done && write_q) begin
      for (int i = 0; i < 4; i++) begin
        if (strb_q[i]) mem[idx_q][8*i +: 8] <= HWDATA[8*i +: 8];
      end
    end
  end

  assign HRDATA    = mem[idx_q];  // whole word, master picks lanes
  assign HREADYOUT = ~(active & (wait_cnt != '0));
  assign HRESP     = ahb_pkg::HRESP_OKAY;

  // master must align HADDR to HSIZE
  a_aligned : assert property (@(posedge CLK) disable iff (!nRST)
    accept |-> (HSIZE != ahb_pkg::HSIZE_HALF || !HADDR[0]) &&
               (HSIZE != ahb_pkg::HSIZE_WORD || HADDR[1:0] == 2'b00))
    else $error("ahb_sram: misaligned HSIZE=%0d HADDR=%h", HSIZE, HADDR);

endmodule

//--- logic/ahb_subsys.sv
/*
  AHB-Lite subsystem top
  generic bus master, address decoder, SRAM slave and
  default slave for unmapped space
*/

`timescale 1ns/100ps

module ahb_subsys (
  input  logic                         CLK,
  input  logic                         nRST,
  input  logic                         ren,
  input  logic                         wen,
  input  logic [ahb_pkg::ADDR_W-1:0]   addr,
  input  logic [ahb_pkg::DATA_W-1:0]   wdata,
  input  logic [ahb_pkg::DATA_W/8-1:0] byte_en,
  output logic [ahb_pkg::DATA_W-1:0]   rdata,
  output logic                         busy,
  output logic                         error
);

  // master side bus
  logic [ahb_pkg::ADDR_W-1:0] HADDR;
  logic [1:0]                 HTRANS;
  logic                       HWRITE;
  logic [2:0]                 HSIZE;
  logic [ahb_pkg::DATA_W-1:0] HWDATA, HRDATA;
  logic                       HREADY, HRESP;
  // per slave
  logic                       HSEL_sram, HSEL_dflt;
  logic [ahb_pkg::DATA_W-1:0] HRDATA_sram;
  logic                       HREADY_sram, HRESP_sram;
  logic                       HREADY_dflt, HRESP_dflt;

  ahb_master u_master (
    .CLK, .nRST, .ren, .wen, .addr, .wdata, .byte_en, .rdata, .busy, .error,
    .HADDR, .HTRANS, .HWRITE, .HSIZE, .HWDATA, .HRDATA, .HREADY, .HRESP
  );

  ahb_decoder u_decoder (
    .CLK, .nRST, .HADDR, .HTRANS,
    .HREADY_sram, .HRESP_sram, .HRDATA_sram, .HREADY_dflt, .HRESP_dflt,
    .HSEL_sram, .HSEL_dflt, .HRDATA, .HREADY, .HRESP
  );

  ahb_sram u_sram (
    .CLK, .nRST, .HSEL(HSEL_sram), .HADDR, .HTRANS, .HWRITE, .HSIZE, .HWDATA,
    .HREADY, .HRDATA(HRDATA_sram), .HREADYOUT(HREADY_sram), .HRESP(HRESP_sram)
  );

  ahb_default_slave u_dflt (
    .CLK, .nRST, .HSEL(HSEL_dflt), .HTRANS, .HREADY,
    .HREADYOUT(HREADY_dflt), .HRESP(HRESP_dflt)
  );

endmodule

//--- testbench/tb_ahb_subsys.sv
/*
  AHB-Lite subsystem testbench
  drives the generic bus with directed and random requests, keeps
  a word model of the SRAM and checks each completion with
  concurrent assertions
*/

`timescale 1ns/100ps

module tb_ahb_subsys;

  localparam int N_RAND = 200;
  // fill, word r/w, byte/half, unmapped, random
  localparam int N_REQ  = ahb_pkg::SRAM_WORDS + 2 + 4 + 3 + N_RAND;
  localparam int WD_CYC = N_REQ * (ahb_pkg::SRAM_WAIT + 3) + 100;

  logic                         CLK;
  logic                         nRST;
  logic                         ren;
  logic                         wen;
  logic [ahb_pkg::ADDR_W-1:0]   addr;
  logic [ahb_pkg::DATA_W-1:0]   wdata;
  logic [ahb_pkg::DATA_W/8-1:0] byte_en;
  logic [ahb_pkg::DATA_W-1:0]   rdata;
  logic                         busy;
  logic                         error;

  logic [31:0] model [ahb_pkg::SRAM_WORDS];  // expected SRAM words
  logic [31:0] exp_rdata;
  logic        exp_err;                      // unmapped address
  int          exp_lat;                      // cycles to completion
  int          start_cyc;
  int          cycle;                        // free-running cycle count
  logic [31:0] rng = 32'h43e67a56;
  string       test_name;
  int          err_rdata;
  int          err_resp;
  int          err_lat;
  int          err_idle;

  ahb_subsys uut (
    .CLK, .nRST, .ren, .wen, .addr, .wdata, .byte_en, .rdata, .busy, .error
  );

  initial begin
    CLK = 1'b0;
    forever #5 CLK = ~CLK;
  end

  always @(posedge CLK) cycle <= cycle + 1;

  // ----------------------------------------
  // checks
  // ----------------------------------------
  // no request means no busy and no error, reset included
  a_idle : assert property (@(posedge CLK) !(ren || wen) |-> !busy && !error)
    else begin
      $display("%s: busy or error high with no request present", test_name);
      err_idle++;
    end

  a_resp : assert property (@(posedge CLK) disable iff (!nRST)
    (ren || wen) && !busy |-> error == exp_err)
    else begin
      $display("mismatch %s error: expected %b actual %b", test_name, exp_err,
               $sampled(error));
      err_resp++;
    end

  a_rdata : assert property (@(posedge CLK) disable iff (!nRST)
    ren && !busy && !exp_err |-> rdata == exp_rdata)
    else begin
      $display("mismatch %s rdata: expected %h actual %h", test_name, exp_rdata,
               $sampled(rdata));
      err_rdata++;
    end

  a_lat : assert property (@(posedge CLK) disable iff (!nRST)
    (ren || wen) && !busy |-> (cycle - start_cyc) == exp_lat)
    else begin
      $display("mismatch %s latency: expected %0d actual %0d", test_name, exp_lat,
               $sampled(cycle) - start_cyc);
      err_lat++;
    end

  // ----------------------------------------
  // helpers
  // ----------------------------------------
  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // preload word, every index bit shows up in it
  function automatic logic [31:0] fill_word(input int i);
    logic [31:0] w;
    w = 32'(i);
    return (w * 32'h0101_0101) ^ 32'hC3A5_5A3C;
  endfunction

  function automatic logic [3:0] pick_lanes(input logic [2:0] k);
    case (k)
      3'd0:    return 4'b0001;
      3'd1:    return 4'b0010;
      3'd2:    return 4'b0100;
      3'd3:    return 4'b1000;
      3'd4:    return 4'b0011;
      3'd5:    return 4'b1100;
      default: return 4'b1111;
    endcase
  endfunction

  task automatic go_idle();
    ren     = 1'b0;
    wen     = 1'b0;
    addr    = '0;
    wdata   = '0;
    byte_en = '0;
  endtask

  // one request, entered and left on a falling edge
  task automatic issue(input logic write, input logic [31:0] a,
                       input logic [31:0] d, input logic [3:0] be);
    logic [31:0]                 off;
    logic [31:0]                 mask;
    logic [ahb_pkg::SRAM_AW-1:0] idx;
    logic                        mapped;
    off    = a - ahb_pkg::SRAM_BASE;  // below base wraps to a large offset
    mapped = off < 32'(4 * ahb_pkg::SRAM_WORDS);
    idx    = off[ahb_pkg::SRAM_AW+1:2];
    mask   = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
    exp_err   = !mapped;
    exp_rdata = model[idx];
    exp_lat   = mapped ? ahb_pkg::SRAM_WAIT + 1 : 2;  // ERROR takes two cycles
    start_cyc = cycle;
    ren     = !write;
    wen     = write;
    addr    = a;
    wdata   = d;
    byte_en = be;
    do begin
      @(negedge CLK);
    end while (busy);
    @(negedge CLK);  // past the completing edge
    if (write && mapped) model[idx] = (model[idx] & ~mask) | (d & mask);
  endtask

  // ----------------------------------------
  // stimulus
  // ----------------------------------------
  initial begin
    logic [31:0] op;
    logic [31:0] a;
    logic [31:0] d;
    int          total;
    nRST      = 1'b0;
    test_name = "reset";
    go_idle();
    repeat (4) @(posedge CLK);
    @(negedge CLK);
    nRST = 1'b1;
    repeat (2) @(negedge CLK);  // idle cycles after reset

    // every SRAM word gets a known value first
    test_name = "fill";
    for (int i = 0; i < ahb_pkg::SRAM_WORDS; i++) begin
      issue(1'b1, ahb_pkg::SRAM_BASE + 32'(4 * i), fill_word(i), 4'b1111);
    end

    test_name = "word_rw";
    issue(1'b1, ahb_pkg::SRAM_BASE + 32'h40, 32'hDEAD_BEEF, 4'b1111);
    issue(1'b0, ahb_pkg::SRAM_BASE + 32'h40, 32'h0, 4'b1111);

    test_name = "byte_half";
    issue(1'b1, ahb_pkg::SRAM_BASE + 32'h14, 32'h1122_3344, 4'b1111);
    issue(1'b1, ahb_pkg::SRAM_BASE + 32'h14, 32'hAAAA_AA5A, 4'b0001);  // lane 0
    issue(1'b1, ahb_pkg::SRAM_BASE + 32'h14, 32'hC0DE_BBBB, 4'b1100);  // lanes 2-3
    issue(1'b0, ahb_pkg::SRAM_BASE + 32'h14, 32'h0, 4'b1111);          // lane 1 kept

    // just above SRAM aliases word 5 if the decode is short
    test_name = "unmapped";
    issue(1'b0, ahb_pkg::SRAM_BASE + 32'(4 * ahb_pkg::SRAM_WORDS) + 32'h14, 32'h0, 4'b1111);
    issue(1'b1, 32'hF000_0014, 32'hFFFF_FFFF, 4'b1111);
    issue(1'b0, ahb_pkg::SRAM_BASE + 32'h14, 32'h0, 4'b1111);

    test_name = "random";
    for (int n = 0; n < N_RAND; n++) begin
      rng = xorshift(rng);
      op  = rng;
      rng = xorshift(rng);
      if (op[3:1] == 3'b000) a = rng | 32'h0001_0000;  // about 1 in 8 unmapped
      else a = ahb_pkg::SRAM_BASE + (rng % 32'(4 * ahb_pkg::SRAM_WORDS));
      rng = xorshift(rng);
      d   = rng;
      issue(op[0], a, d, pick_lanes(3'(op[31:8] % 7)));
    end

    go_idle();
    repeat (2) @(negedge CLK);
    total = err_rdata + err_resp + err_lat + err_idle;
    $display("errors: rdata %0d, error flag %0d, latency %0d, idle %0d",
             err_rdata, err_resp, err_lat, err_idle);
    if (total == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

  // watchdog, a stuck busy ends the run here
  initial begin
    repeat (WD_CYC) @(posedge CLK);
    $display("timeout: requests did not complete within %0d cycles", WD_CYC);
    $display("FAIL: see errors above");
    $finish;
  end

endmodule

//--- vlog.f
logic/ahb_pkg.sv
logic/ahb_master.sv
logic/ahb_decoder.sv
logic/ahb_sram.sv
logic/ahb_default_slave.sv
logic/ahb_subsys.sv
testbench/tb_ahb_subsys.sv
